// ==== all.f ====
sensor_link_pkg.sv
mpr121_pkg.sv
mpr_bus_master.sv
mpr_sequencer.sv
sense_cmd_decoder.sv
uart_reporter.sv
sensor_core.sv
tb_mpr121_model.sv
tb_sensor_core.sv

// ==== mpr121_pkg.sv ====
/*
 * MPR121 register map and the fixed setup table written after reset
 * values follow the datasheet recommendation, autoconfig is not used
 * ELE_CONFIG is written last, by the run/stop logic, never by setup
 */
package mpr121_pkg;

	//==================================================
	// register addresses
	//==================================================
	localparam logic [7:0] MPR_TOUCH_STATUS_0 = 8'h00; // ele0..ele7, read only
	localparam logic [7:0] MPR_TOUCH_STATUS_1 = 8'h01; // ele8..ele11 in bits 3:0
	localparam logic [7:0] MPR_ELE_CONFIG = 8'h5E;
	localparam logic [7:0] MPR_ELE_STOP = 8'h00; // all electrodes off

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} mpr_reg_pair_t;

	//==================================================
	// setup table, written in order
	//==================================================
	localparam int MPR_SETUP_LEN = 14;

	localparam mpr_reg_pair_t MPR_SETUP_TABLE [MPR_SETUP_LEN] = '{
		'{8'h2B, 8'h01}, // MHDR rising
		'{8'h2C, 8'h01}, // NHDR rising
		'{8'h2D, 8'h0E}, // NCLR rising
		'{8'h2E, 8'h00}, // FDLR rising
		'{8'h2F, 8'h01}, // MHDF falling
		'{8'h30, 8'h05}, // NHDF falling
		'{8'h31, 8'h01}, // NCLF falling
		'{8'h32, 8'h00}, // FDLF falling
		'{8'h33, 8'h00}, // NHDT touched
		'{8'h34, 8'h00}, // NCLT touched
		'{8'h35, 8'h00}, // FDLT touched
		'{8'h5B, 8'h00}, // debounce off
		'{8'h5C, 8'h10}, // CDC config, 16uA
		'{8'h5D, 8'h20} // CDT config, 0.5us
	};

	//==================================================
	// bus side
	//==================================================
	// request to the external register master
	typedef struct packed {
		logic [7:0] reg_addr;
		logic [7:0] wr_data;
		logic wr_en; // one cycle strobe
		logic rd_en; // one cycle strobe
	} mpr_bus_req_t;

	// one operation from the sequencer to the bus master
	typedef struct packed {
		logic wr; // 1 write, 0 read
		logic [7:0] addr;
		logic [7:0] data; // ignored on reads
	} mpr_op_t;

endpackage

// ==== mpr_bus_master.sv ====
/*
 * runs one MPR121 register write or read on the external bus master
 * the bus must raise i_busy the cycle after the strobe and drop it when finished
 * i_op_start is only accepted while at rest, one op in flight
 */
`timescale 1ns/100ps
module mpr_bus_master (
	input logic i_CLK,
	input logic i_RST,
	input mpr121_pkg::mpr_op_t i_op,
	input logic i_op_start, // one cycle pulse
	output logic o_op_done, // one cycle pulse
	output logic o_op_fail, // one cycle pulse
	output logic [7:0] o_rd_data, // valid with o_op_done
	output mpr121_pkg::mpr_bus_req_t o_req,
	input logic [7:0] i_rd_data,
	input logic i_busy,
	input logic i_fail
);
	import mpr121_pkg::*;

	typedef enum logic [1:0] {ST_DONE, ST_SETUP, ST_ENABLE, ST_CONFIRM} bm_state_e;

	bm_state_e r_state; // ST_DONE is the rest state
	mpr_op_t r_op; // held for the whole transaction
	logic w_en;

	//==================================================
	// transaction FSM
	//==================================================
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_DONE;
			r_op <= '0;
			o_op_done <= 1'b0;
			o_op_fail <= 1'b0;
		end else begin
			o_op_done <= 1'b0;
			o_op_fail <= 1'b0;
			case (r_state)
				ST_DONE: if (i_op_start) begin
					r_op <= i_op;
					r_state <= ST_SETUP;
				end
				ST_SETUP: r_state <= ST_ENABLE; // addr/data settle one cycle
				ST_ENABLE: r_state <= ST_CONFIRM; // strobe cycle
				ST_CONFIRM: if (!i_busy) begin // busy already up since strobe
					o_op_done <= !i_fail;
					o_op_fail <= i_fail;
					r_state <= ST_DONE;
				end
				default: r_state <= ST_DONE;
			endcase
		end
	end

	always_ff @(posedge i_CLK) begin
		if (r_state == ST_CONFIRM && !i_busy) o_rd_data <= i_rd_data;
	end

	// bus request straight from the held op
	assign w_en = (r_state == ST_ENABLE);
	assign o_req.reg_addr = r_op.addr;
	assign o_req.wr_data = r_op.data;
	assign o_req.wr_en = w_en && r_op.wr;
	assign o_req.rd_en = w_en && !r_op.wr;

	// confirm state relies on busy being up right after the strobe
	a_busy_rise: assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_req.wr_en || o_req.rd_en) |=> i_busy)
		else $error("bus did not raise busy the cycle after the strobe");

	// sequencer keeps one op in flight
	a_start_idle: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_op_start |-> r_state == ST_DONE)
		else $error("op start while bus master busy");

endmodule

// ==== mpr_sequencer.sv ====
/*
 * MPR121 control: setup table after reset, run/stop, touch polling, register reads
 * a failed op sets o_error until reset; during setup the table restarts from entry 0
 * a new poll needs read_permit to drop and rise again, register reads only while stopped
 */
`timescale 1ns/100ps
module mpr_sequencer #(
	parameter int N_ELECTRODES = 12 // 1..12
) (
	input logic i_CLK,
	input logic i_RST,
	input logic i_run_mode,
	input logic i_read_permit,
	input logic i_reg_req,
	input logic [7:0] i_reg_addr,
	output logic o_touch_valid, // one cycle pulse
	output logic [15:0] o_touch_status,
	output logic o_reg_valid, // one cycle pulse
	output logic [7:0] o_reg_addr,
	output logic [7:0] o_reg_data,
	output logic o_chip_set,
	output logic o_run_set,
	output logic o_error, // sticky
	output mpr121_pkg::mpr_bus_req_t o_mpr_req,
	input logic [7:0] i_mpr_rd_data,
	input logic i_mpr_busy,
	input logic i_mpr_fail
);
	import mpr121_pkg::*;

	localparam logic [7:0] ELE_RUN = 8'h80 + 8'(N_ELECTRODES); // ele0..N-1 on
	localparam logic [15:0] TOUCH_MASK = 16'((32'd1 << N_ELECTRODES) - 32'd1);
	localparam bit READ_STAT1 = (N_ELECTRODES > 8); // ele8+ live in status 1

	typedef enum logic [1:0] {ST_SETUP, ST_IDLE, ST_WAIT} seq_state_e;
	typedef enum logic [2:0] {JOB_SETUP, JOB_RUN, JOB_STOP, JOB_STAT0, JOB_STAT1,
		JOB_REG} seq_job_e;

	seq_state_e r_state;
	seq_job_e r_job; // what the op in flight is for
	logic [3:0] r_setup_idx;
	mpr_op_t r_op;
	logic r_op_start;
	logic r_poll_hold; // frame made, wait for permit low
	logic r_reg_hold; // same for register reads
	logic [7:0] r_stat0;
	logic w_op_done;
	logic w_op_fail;
	logic [7:0] w_rd_data;
	logic [7:0] w_stat0;
	logic [3:0] w_stat1;
	logic [15:0] w_touch_word;

	//==================================================
	// control FSM
	//==================================================
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_SETUP;
			r_job <= JOB_SETUP;
			r_setup_idx <= '0;
			r_op <= '0;
			r_op_start <= 1'b0;
			r_poll_hold <= 1'b0;
			r_reg_hold <= 1'b0;
			o_touch_valid <= 1'b0;
			o_touch_status <= '0;
			o_reg_valid <= 1'b0;
			o_reg_addr <= '0;
			o_chip_set <= 1'b0;
			o_run_set <= 1'b0;
			o_error <= 1'b0;
		end else begin
			r_op_start <= 1'b0;
			o_touch_valid <= 1'b0;
			o_reg_valid <= 1'b0;
			if (!i_read_permit) r_poll_hold <= 1'b0;
			if (!i_reg_req) r_reg_hold <= 1'b0;
			case (r_state)
				ST_SETUP: begin // next table entry
					r_op <= '{1'b1, MPR_SETUP_TABLE[r_setup_idx].addr,
						MPR_SETUP_TABLE[r_setup_idx].data};
					r_op_start <= 1'b1;
					r_job <= JOB_SETUP;
					r_state <= ST_WAIT;
				end
				ST_IDLE: begin
					if (i_run_mode != o_run_set) begin // run/stop change wins
						r_op <= '{1'b1, MPR_ELE_CONFIG, i_run_mode ? ELE_RUN : MPR_ELE_STOP};
						r_op_start <= 1'b1;
						r_job <= i_run_mode ? JOB_RUN : JOB_STOP;
						r_state <= ST_WAIT;
					end else if (o_run_set && i_read_permit && !r_poll_hold) begin
						r_op <= '{1'b0, MPR_TOUCH_STATUS_0, 8'h00};
						r_op_start <= 1'b1;
						r_job <= JOB_STAT0;
						r_state <= ST_WAIT;
					end else if (!o_run_set && i_reg_req && !r_reg_hold) begin
						r_op <= '{1'b0, i_reg_addr, 8'h00};
						o_reg_addr <= i_reg_addr; // echoed in the reply
						r_op_start <= 1'b1;
						r_job <= JOB_REG;
						r_state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (w_op_fail) begin
						o_error <= 1'b1;
						r_setup_idx <= '0;
						r_state <= o_chip_set ? ST_IDLE : ST_SETUP;
					end else if (w_op_done) begin
						r_state <= ST_IDLE; // most jobs end here
						case (r_job)
							JOB_SETUP: begin
								if (r_setup_idx == 4'(MPR_SETUP_LEN - 1)) begin
									o_chip_set <= 1'b1;
								end else begin
									r_setup_idx <= r_setup_idx + 4'd1;
									r_state <= ST_SETUP;
								end
							end
							JOB_RUN: o_run_set <= 1'b1;
							JOB_STOP: o_run_set <= 1'b0;
							JOB_REG: begin
								o_reg_valid <= 1'b1;
								r_reg_hold <= 1'b1;
							end
							default: begin // status reads
								if (r_job == JOB_STAT0 && READ_STAT1) begin
									r_op <= '{1'b0, MPR_TOUCH_STATUS_1, 8'h00};
									r_op_start <= 1'b1;
									r_job <= JOB_STAT1;
									r_state <= ST_WAIT;
								end else begin
									r_poll_hold <= 1'b1;
									if (i_read_permit) begin // 'S' mid poll drops the frame
										o_touch_status <= w_touch_word;
										o_touch_valid <= 1'b1;
									end
								end
							end
						endcase
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_op_done && r_job == JOB_STAT0) r_stat0 <= w_rd_data;
		if (w_op_done && r_job == JOB_REG) o_reg_data <= w_rd_data;
	end

	// status 1 on top of status 0, unused electrodes masked
	assign w_stat0 = (r_job == JOB_STAT0) ? w_rd_data : r_stat0;
	assign w_stat1 = (r_job == JOB_STAT1) ? w_rd_data[3:0] : 4'h0;
	assign w_touch_word = {4'h0, w_stat1, w_stat0} & TOUCH_MASK;

	mpr_bus_master u_bus_master (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_op(r_op),
		.i_op_start(r_op_start),
		.o_op_done(w_op_done),
		.o_op_fail(w_op_fail),
		.o_rd_data(w_rd_data),
		.o_req(o_mpr_req),
		.i_rd_data(i_mpr_rd_data),
		.i_busy(i_mpr_busy),
		.i_fail(i_mpr_fail)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_sensor_core with Verilator, result taken from sim.log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_sensor_core \
	-f all.f \
	-o tb_sensor_core

./obj_dir/tb_sensor_core | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== sense_cmd_decoder.sv ====
/*
 * PC command state: run mode, touch read permission, one register read request
 * a command takes effect one cycle after its rx pulse
 * an 'm' arriving while a register request is open is dropped
 */
`timescale 1ns/100ps
module sense_cmd_decoder (
	input logic i_CLK,
	input logic i_RST,
	input sensor_link_pkg::uart_rx_word_t i_rx,
	input logic i_rx_valid, // one cycle pulse
	input logic i_touch_sent, // reporter sent a touch frame
	input logic i_reg_sent, // reporter sent a register frame
	output logic o_run_mode,
	output logic o_read_permit,
	output logic o_reg_req,
	output logic [7:0] o_reg_addr
);
	import sensor_link_pkg::*;

	uart_rx_word_t r_rx; // captured command
	logic r_rx_pend; // decode it this cycle
	logic w_new_req;

	assign w_new_req = r_rx_pend && (r_rx.tag == TAG_MPR_REG) && !o_reg_req;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_rx_pend <= 1'b0;
			o_run_mode <= 1'b0;
			o_read_permit <= 1'b0;
			o_reg_req <= 1'b0;
		end else begin
			r_rx_pend <= i_rx_valid;
			if (i_touch_sent) o_read_permit <= 1'b0; // frame out, wait for 'f'
			if (i_reg_sent) o_reg_req <= 1'b0;
			if (r_rx_pend) begin
				case (r_rx.tag)
					TAG_RUN: begin
						o_run_mode <= 1'b1;
						o_read_permit <= 1'b1;
					end
					TAG_STOP: begin
						o_run_mode <= 1'b0;
						o_read_permit <= 1'b0;
					end
					TAG_MPR_FINISH: o_read_permit <= 1'b1;
					TAG_MPR_REG: if (w_new_req) o_reg_req <= 1'b1;
					default: ; // unknown tags ignored
				endcase
			end
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_rx_valid) r_rx <= i_rx;
		if (w_new_req) o_reg_addr <= r_rx.arg;
	end

	// one register frame per open request
	a_reg_sent: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_reg_sent |-> o_reg_req)
		else $error("register frame sent with no open request");

endmodule

// ==== sensor_core.sv ====
/*
 * touch-sensor link top: pc commands in, MPR121 over an external register master, frames out
 * N_ELECTRODES sets the electrodes enabled at run; 8 or fewer skips status register 1
 * o_touch_status follows the last touch frame
 */
`timescale 1ns/100ps
module sensor_core #(
	parameter int N_ELECTRODES = 12 // 1..12
) (
	input logic i_CLK,
	input logic i_RST,
	// pc link
	input sensor_link_pkg::uart_rx_word_t i_uart_rx,
	input logic i_uart_rx_valid,
	input logic i_uart_tx_ready,
	output sensor_link_pkg::uart_tx_frame_u o_uart_tx,
	output logic o_uart_tx_valid,
	// mpr121 bus
	output mpr121_pkg::mpr_bus_req_t o_mpr_req,
	input logic [7:0] i_mpr_rd_data,
	input logic i_mpr_busy,
	input logic i_mpr_fail,
	// status
	output logic [11:0] o_touch_status,
	output logic o_mpr_error,
	output logic o_chip_set,
	output logic o_run_set
);
	//==================================================
	// decoder -> sequencer -> reporter
	//==================================================
	logic w_run_mode;
	logic w_read_permit;
	logic w_reg_req;
	logic [7:0] w_req_addr; // address asked by the pc
	logic w_touch_valid;
	logic [15:0] w_touch_status;
	logic w_reg_valid;
	logic [7:0] w_reg_addr; // address of the completed read
	logic [7:0] w_reg_data;
	logic w_touch_sent;
	logic w_reg_sent;

	assign o_touch_status = w_touch_status[11:0];

	sense_cmd_decoder u_decoder (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_rx(i_uart_rx),
		.i_rx_valid(i_uart_rx_valid),
		.i_touch_sent(w_touch_sent),
		.i_reg_sent(w_reg_sent),
		.o_run_mode(w_run_mode),
		.o_read_permit(w_read_permit),
		.o_reg_req(w_reg_req),
		.o_reg_addr(w_req_addr)
	);

	mpr_sequencer #(
		.N_ELECTRODES(N_ELECTRODES)
	) u_sequencer (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_run_mode(w_run_mode),
		.i_read_permit(w_read_permit),
		.i_reg_req(w_reg_req),
		.i_reg_addr(w_req_addr),
		.o_touch_valid(w_touch_valid),
		.o_touch_status(w_touch_status),
		.o_reg_valid(w_reg_valid),
		.o_reg_addr(w_reg_addr),
		.o_reg_data(w_reg_data),
		.o_chip_set(o_chip_set),
		.o_run_set(o_run_set),
		.o_error(o_mpr_error),
		.o_mpr_req(o_mpr_req),
		.i_mpr_rd_data(i_mpr_rd_data),
		.i_mpr_busy(i_mpr_busy),
		.i_mpr_fail(i_mpr_fail)
	);

	uart_reporter u_reporter (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_touch_valid(w_touch_valid),
		.i_touch_status(w_touch_status),
		.i_reg_valid(w_reg_valid),
		.i_reg_addr(w_reg_addr),
		.i_reg_data(w_reg_data),
		.i_tx_ready(i_uart_tx_ready),
		.o_tx(o_uart_tx),
		.o_tx_valid(o_uart_tx_valid),
		.o_touch_sent(w_touch_sent),
		.o_reg_sent(w_reg_sent)
	);

endmodule

// ==== sensor_link_pkg.sv ====
/*
 * PC link types. tags are ASCII characters, one command word is tag + one argument byte
 * a tx word carries either a touch frame or a register frame, the tag tells which
 */
package sensor_link_pkg;

	//==================================================
	// command and frame tags
	//==================================================
	typedef enum logic [7:0] {
		TAG_RUN = 8'h52, // 'R' electrodes on, start polling
		TAG_STOP = 8'h53, // 'S' electrodes off
		TAG_MPR_FINISH = 8'h66, // 'f' pc took the last touch frame
		TAG_MPR_REG = 8'h6D, // 'm' register read, reply uses it too
		TAG_MPR_DATA = 8'h4D // 'M' touch frame
	} uart_tag_e;

	// word from the pc, raw tag so unknown characters pass through
	typedef struct packed {
		logic [7:0] tag;
		logic [7:0] arg; // register address for 'm'
	} uart_rx_word_t;

	//==================================================
	// 40 bit frames to the pc
	//==================================================
	typedef struct packed {
		uart_tag_e tag; // 'M'
		logic [15:0] status; // {4'b0, ele11..ele0}
		logic [15:0] pad;
	} touch_frame_t;

	typedef struct packed {
		uart_tag_e tag; // 'm'
		logic [7:0] addr;
		logic [7:0] data;
		logic [15:0] pad;
	} reg_frame_t;

	typedef union packed {
		touch_frame_t touch;
		reg_frame_t regs;
	} uart_tx_frame_u;

endpackage

// ==== tb_mpr121_model.sv ====
/*
 * behavioral MPR121 behind the register master, 256 byte register file
 * busy rises the cycle after a strobe and lasts 1 to 4 cycles
 * a rising i_fail_arm makes the next read fail, writes logged as count + last pair
 */
`timescale 1ns/100ps
module tb_mpr121_model (
	input logic i_CLK,
	input logic i_RST,
	input mpr121_pkg::mpr_bus_req_t i_req,
	input logic i_poke_en, // testbench preload
	input mpr121_pkg::mpr_reg_pair_t i_poke,
	input logic i_fail_arm,
	output logic [7:0] o_rd_data,
	output logic o_busy,
	output logic o_fail,
	output logic [7:0] o_wr_count,
	output mpr121_pkg::mpr_reg_pair_t o_last_wr
);
	import mpr121_pkg::*;

	logic [7:0] r_regs [256];
	logic [2:0] r_busy_cnt; // busy cycles left
	logic r_rd; // op in progress is a read
	logic [7:0] r_addr;
	logic r_arm_d;
	logic r_fail_pend; // next read fails

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			for (int i = 0; i < 256; i++) begin
				r_regs[i] <= 8'(i * 37 + 11); // fill, differs per address
			end
			r_busy_cnt <= '0;
			r_rd <= 1'b0;
			r_addr <= '0;
			r_arm_d <= 1'b0;
			r_fail_pend <= 1'b0;
			o_rd_data <= '0;
			o_busy <= 1'b0;
			o_fail <= 1'b0;
			o_wr_count <= '0;
			o_last_wr <= '0;
		end else begin
			r_arm_d <= i_fail_arm;
			if (i_fail_arm && !r_arm_d) r_fail_pend <= 1'b1;
			if (i_poke_en) r_regs[i_poke.addr] <= i_poke.data;
			if (i_req.wr_en || i_req.rd_en) begin
				o_busy <= 1'b1; // up the cycle after the strobe
				o_fail <= 1'b0;
				r_busy_cnt <= 3'($urandom % 4) + 3'd1;
				r_rd <= i_req.rd_en;
				r_addr <= i_req.reg_addr;
				if (i_req.wr_en) begin
					r_regs[i_req.reg_addr] <= i_req.wr_data;
					o_wr_count <= o_wr_count + 8'd1;
					o_last_wr <= '{i_req.reg_addr, i_req.wr_data};
				end
			end else if (o_busy) begin
				r_busy_cnt <= r_busy_cnt - 3'd1;
				if (r_busy_cnt == 3'd1) begin // last busy cycle
					o_busy <= 1'b0;
					if (r_rd) begin
						o_rd_data <= r_regs[r_addr];
						o_fail <= r_fail_pend;
						r_fail_pend <= 1'b0; // one shot
					end
				end
			end
		end
	end

endmodule

// ==== tb_sensor_core.sv ====
/*
 * testbench for sensor_core with 12 electrodes and a behavioral MPR121
 * the assertions below do the checking, stimulus walks 'm' during setup, 'R', 'f', error, 'S', 'm'
 * tx_ready toggles at random for the whole run
 */
`timescale 1ns/100ps
module tb_sensor_core;
	import sensor_link_pkg::*;
	import mpr121_pkg::*;

	localparam int N_ELE = 12;
	localparam int OP_CYCLES = 10; // worst bus op with sequencer steps
	localparam int N_OPS = MPR_SETUP_LEN + 12;
	localparam int QUIET_CYCLES = 30;
	localparam int CYCLE_LIMIT = 2 * (3 + N_OPS * OP_CYCLES + 5 * QUIET_CYCLES + 100);

	logic i_CLK;
	logic i_RST;
	uart_rx_word_t rx;
	logic rx_valid;
	logic tx_ready;
	uart_tx_frame_u tx;
	logic tx_valid;
	mpr_bus_req_t mpr_req;
	logic [7:0] mpr_rd_data;
	logic mpr_busy;
	logic mpr_fail;
	logic [11:0] touch_status;
	logic mpr_error;
	logic chip_set;
	logic run_set;
	logic poke_en;
	mpr_reg_pair_t poke;
	logic fail_arm;
	logic [7:0] wr_count;
	mpr_reg_pair_t last_wr;
	mpr_reg_pair_t exp_setup;

	// expected state, set by the stimulus
	int permits; // touch frames allowed so far
	int reg_asks;
	logic [7:0] exp_reg_addr;
	logic [7:0] exp_reg_data;
	logic [15:0] exp_touch;
	logic [7:0] exp_ele;
	logic fail_armed;
	// seen on the bus
	int m_frames;
	int r_frames;
	int cycles = 0;
	int errors = 0;

	sensor_core #(
		.N_ELECTRODES(N_ELE)
	) UUT (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_uart_rx(rx),
		.i_uart_rx_valid(rx_valid),
		.i_uart_tx_ready(tx_ready),
		.o_uart_tx(tx),
		.o_uart_tx_valid(tx_valid),
		.o_mpr_req(mpr_req),
		.i_mpr_rd_data(mpr_rd_data),
		.i_mpr_busy(mpr_busy),
		.i_mpr_fail(mpr_fail),
		.o_touch_status(touch_status),
		.o_mpr_error(mpr_error),
		.o_chip_set(chip_set),
		.o_run_set(run_set)
	);

	tb_mpr121_model u_model (
		.i_CLK(i_CLK),
		.i_RST(i_RST),
		.i_req(mpr_req),
		.i_poke_en(poke_en),
		.i_poke(poke),
		.i_fail_arm(fail_arm),
		.o_rd_data(mpr_rd_data),
		.o_busy(mpr_busy),
		.o_fail(mpr_fail),
		.o_wr_count(wr_count),
		.o_last_wr(last_wr)
	);

	initial begin
		i_CLK = 1'b0;
		forever #4 i_CLK = ~i_CLK; // 8 ns
	end

	initial begin
		tx_ready = 1'b0;
		forever begin
			@(posedge i_CLK);
			#1;
			tx_ready = 1'($urandom % 2);
		end
	end

	// frame counters and watchdog
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			m_frames <= 0;
			r_frames <= 0;
		end else if (tx_valid) begin
			if (tx.touch.tag == TAG_MPR_DATA) m_frames <= m_frames + 1;
			if (tx.regs.tag == TAG_MPR_REG) r_frames <= r_frames + 1;
		end
	end

	always @(posedge i_CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("%0d errors, %0d touch frames, %0d register frames", errors + 1,
				m_frames, r_frames);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//==================================================
	// checks
	//==================================================
	always_comb begin
		exp_setup = '{8'hFF, 8'hFF}; // no table entry left
		if (wr_count < 8'(MPR_SETUP_LEN)) exp_setup = MPR_SETUP_TABLE[wr_count[3:0]];
	end

	a_setup_wr: assert property (@(posedge i_CLK) disable iff (i_RST)
		(mpr_req.wr_en && !chip_set) |-> {mpr_req.reg_addr, mpr_req.wr_data} == exp_setup)
		else begin
			errors++;
			$display("Fail o_mpr_req write = %h expected %h",
				$sampled({mpr_req.reg_addr, mpr_req.wr_data}), $sampled(exp_setup));
		end

	a_chip_set: assert property (@(posedge i_CLK) disable iff (i_RST)
		$rose(chip_set) |-> wr_count == 8'(MPR_SETUP_LEN))
		else begin
			errors++;
			$display("Fail write count at o_chip_set = %h expected %h", $sampled(wr_count),
				8'(MPR_SETUP_LEN));
		end

	a_no_early_rd: assert property (@(posedge i_CLK) disable iff (i_RST)
		mpr_req.rd_en |-> chip_set)
		else begin
			errors++;
			$display("register read started before setup finished");
		end

	// after setup only ELE_CONFIG is written
	a_ele_wr: assert property (@(posedge i_CLK) disable iff (i_RST)
		(mpr_req.wr_en && chip_set) |->
		(mpr_req.reg_addr == MPR_ELE_CONFIG && mpr_req.wr_data == exp_ele))
		else begin
			errors++;
			$display("Fail o_mpr_req write = %h expected %h",
				$sampled({mpr_req.reg_addr, mpr_req.wr_data}), {MPR_ELE_CONFIG, exp_ele});
		end

	a_run_set: assert property (@(posedge i_CLK) disable iff (i_RST)
		$changed(run_set) |->
		(last_wr == {MPR_ELE_CONFIG, exp_ele} && run_set == (exp_ele != 8'h00)))
		else begin
			errors++;
			$display("Fail o_run_set = %h with last write %h expected write %h",
				$sampled(run_set), $sampled(last_wr), {MPR_ELE_CONFIG, exp_ele});
		end

	a_tx_ready: assert property (@(posedge i_CLK) disable iff (i_RST)
		tx_valid |-> tx_ready)
		else begin
			errors++;
			$display("frame sent while tx ready was low");
		end

	a_tx_shape: assert property (@(posedge i_CLK) disable iff (i_RST)
		tx_valid |-> ((tx.touch.tag == TAG_MPR_DATA || tx.touch.tag == TAG_MPR_REG)
		&& tx.touch.pad == 16'h0000))
		else begin
			errors++;
			$display("Fail o_uart_tx = %h expected tag 4d or 6d and zero padding",
				$sampled(tx));
		end

	a_touch_data: assert property (@(posedge i_CLK) disable iff (i_RST)
		(tx_valid && tx.touch.tag == TAG_MPR_DATA) |-> tx.touch.status == exp_touch)
		else begin
			errors++;
			$display("Fail o_uart_tx.touch.status = %h expected %h",
				$sampled(tx.touch.status), exp_touch);
		end

	a_touch_out: assert property (@(posedge i_CLK) disable iff (i_RST)
		(tx_valid && tx.touch.tag == TAG_MPR_DATA) |-> touch_status == exp_touch[11:0])
		else begin
			errors++;
			$display("Fail o_touch_status = %h expected %h", $sampled(touch_status),
				exp_touch[11:0]);
		end

	a_touch_permit: assert property (@(posedge i_CLK) disable iff (i_RST)
		(tx_valid && tx.touch.tag == TAG_MPR_DATA) |-> m_frames < permits)
		else begin
			errors++;
			$display("touch frame sent without a read permission from the pc");
		end

	a_reg_data: assert property (@(posedge i_CLK) disable iff (i_RST)
		(tx_valid && tx.regs.tag == TAG_MPR_REG) |->
		(tx.regs.addr == exp_reg_addr && tx.regs.data == exp_reg_data))
		else begin
			errors++;
			$display("Fail o_uart_tx.regs = %h expected %h",
				$sampled({tx.regs.addr, tx.regs.data}), {exp_reg_addr, exp_reg_data});
		end

	a_reg_once: assert property (@(posedge i_CLK) disable iff (i_RST)
		(tx_valid && tx.regs.tag == TAG_MPR_REG) |-> r_frames < reg_asks)
		else begin
			errors++;
			$display("register frame sent that no 'm' command asked for");
		end

	a_error_cause: assert property (@(posedge i_CLK) disable iff (i_RST)
		$rose(mpr_error) |-> fail_armed)
		else begin
			errors++;
			$display("o_mpr_error rose with no bus failure injected");
		end

	a_error_sticky: assert property (@(posedge i_CLK) disable iff (i_RST)
		!$fell(mpr_error))
		else begin
			errors++;
			$display("o_mpr_error dropped before reset");
		end

	//==================================================
	// stimulus
	//==================================================
	task automatic step(); // inputs change 1 ns after the edge
		@(posedge i_CLK);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) step();
	endtask

	task automatic send_cmd(input logic [7:0] tag, input logic [7:0] arg);
		rx.tag = tag;
		rx.arg = arg;
		rx_valid = 1'b1;
		step();
		rx_valid = 1'b0;
	endtask

	task automatic poke_reg(input logic [7:0] addr, input logic [7:0] data);
		poke = '{addr, data};
		poke_en = 1'b1;
		step();
		poke_en = 1'b0;
	endtask

	// new status regs, status 1 upper nibble is junk the core must drop
	task automatic load_touch();
		logic [7:0] s0;
		logic [7:0] s1;
		s0 = 8'($urandom);
		s1 = 8'($urandom);
		poke_reg(MPR_TOUCH_STATUS_0, s0);
		poke_reg(MPR_TOUCH_STATUS_1, s1);
		exp_touch = {4'h0, s1[3:0], s0};
	endtask

	initial begin
		void'($urandom(68));
		i_RST = 1'b1;
		rx = '0;
		rx_valid = 1'b0;
		poke_en = 1'b0;
		poke = '0;
		fail_arm = 1'b0;
		permits = 0;
		reg_asks = 0;
		exp_reg_addr = '0;
		exp_reg_data = '0;
		exp_touch = '0;
		exp_ele = 8'h00;
		fail_armed = 1'b0;
		repeat (3) @(posedge i_CLK);
		#1;
		i_RST = 1'b0;

		exp_reg_addr = 8'h41; // single register read, asked while setup runs
		exp_reg_data = 8'($urandom);
		poke_reg(exp_reg_addr, exp_reg_data);
		reg_asks++;
		send_cmd(TAG_MPR_REG, exp_reg_addr);
		while (!chip_set) step(); // setup table
		while (r_frames < reg_asks) step();
		wait_cycles(QUIET_CYCLES);

		load_touch(); // run, first frame
		exp_ele = 8'h8C; // 12 electrodes on
		permits++;
		send_cmd(TAG_RUN, 8'h00);
		while (!run_set) step();
		while (m_frames < permits) step();
		wait_cycles(QUIET_CYCLES); // no frame without 'f'

		load_touch();
		permits++;
		send_cmd(TAG_MPR_FINISH, 8'h00);
		while (m_frames < permits) step();

		fail_armed = 1'b1; // failed status read, then a clean poll
		fail_arm = 1'b1;
		step();
		fail_arm = 1'b0;
		permits++;
		send_cmd(TAG_MPR_FINISH, 8'h00);
		while (!mpr_error) step();
		while (m_frames < permits) step();

		exp_ele = 8'h00; // stop
		send_cmd(TAG_STOP, 8'h00);
		while (run_set) step();
		wait_cycles(QUIET_CYCLES);

		exp_reg_addr = MPR_ELE_CONFIG; // reads back the stop value
		exp_reg_data = 8'h00;
		reg_asks++;
		send_cmd(TAG_MPR_REG, exp_reg_addr);
		while (r_frames < reg_asks) step();
		wait_cycles(QUIET_CYCLES);

		$display("%0d errors, %0d touch frames, %0d register frames", errors, m_frames,
			r_frames);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== uart_reporter.sv ====
/*
 * builds 40 bit frames for the pc, one pending frame of each kind
 * touch frame goes before a register frame, o_tx/o_tx_valid are combinational
 * a frame waits with no loss while tx_ready is low
 */
`timescale 1ns/100ps
module uart_reporter (
	input logic i_CLK,
	input logic i_RST,
	input logic i_touch_valid,
	input logic [15:0] i_touch_status,
	input logic i_reg_valid,
	input logic [7:0] i_reg_addr,
	input logic [7:0] i_reg_data,
	input logic i_tx_ready,
	output sensor_link_pkg::uart_tx_frame_u o_tx,
	output logic o_tx_valid, // one cycle per frame
	output logic o_touch_sent,
	output logic o_reg_sent
);
	import sensor_link_pkg::*;

	logic r_touch_pend;
	logic r_reg_pend;
	logic [15:0] r_touch_status;
	logic [7:0] r_reg_addr;
	logic [7:0] r_reg_data;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_touch_pend <= 1'b0;
			r_reg_pend <= 1'b0;
		end else begin
			if (o_touch_sent) r_touch_pend <= 1'b0;
			if (o_reg_sent) r_reg_pend <= 1'b0;
			if (i_touch_valid) r_touch_pend <= 1'b1; // new data wins over a clear
			if (i_reg_valid) r_reg_pend <= 1'b1;
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_touch_valid) r_touch_status <= i_touch_status;
		if (i_reg_valid) begin
			r_reg_addr <= i_reg_addr;
			r_reg_data <= i_reg_data;
		end
	end

	assign o_tx_valid = i_tx_ready && (r_touch_pend || r_reg_pend);
	assign o_touch_sent = o_tx_valid && r_touch_pend; // touch first
	assign o_reg_sent = o_tx_valid && !r_touch_pend;

	always_comb begin
		o_tx = '0; // padding stays zero
		if (r_touch_pend) begin
			o_tx.touch.tag = TAG_MPR_DATA;
			o_tx.touch.status = r_touch_status;
		end else begin
			o_tx.regs.tag = TAG_MPR_REG;
			o_tx.regs.addr = r_reg_addr;
			o_tx.regs.data = r_reg_data;
		end
	end

	// sequencer only polls again after the last touch frame left
	a_no_overrun: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_touch_valid |-> (!r_touch_pend || o_touch_sent))
		else $error("touch frame overwritten before it was sent");

endmodule
